//--- Bender.yml
package:
  name: i2c_subsys

sources:
  - i2c_pkg.sv
  - i2c_bit_master.sv
  - i2c_cmd_engine.sv
  - i2c_init_seq.sv
  - i2c_subsys.sv
  - target: test
    files:
      - tb_i2c_slave.sv
      - tb_i2c_subsys.sv

//--- i2c_bit_master.sv
module i2c_bit_master
  import i2c_pkg::*;
(
  input  logic    clk,
  input  logic    rst_i,
  input  bit_op_e op_i,
  input  logic    start_i,
  input  byte_t   wdata_i,
  input  logic    ack_out_i,
  output logic    done_o,
  output byte_t   rdata_o,
  output logic    ack_in_o,
  input  logic    scl_i,
  input  logic    sda_i,
  output logic    scl_t_o,
  output logic    sda_t_o
);

  bit_op_e  op_q;
  logic     busy;
  div_cnt_t div_cnt;
  logic [1:0] quarter;
  logic [3:0] bit_cnt;
  byte_t    tx_sr;
  logic     ack_out_q;
  logic     scl_hold;   // line levels kept between operations
  logic     sda_hold;
  logic     quarter_end;
  logic     last_bit;
  logic     bit_val;
  logic     scl_lvl;
  logic     sda_lvl;

  assign quarter_end = busy && (div_cnt == div_cnt_t'(I2C_DIV - 1));
  assign last_bit    = (op_q == OP_START) || (op_q == OP_STOP) || (bit_cnt == 4'd8);

  always_comb begin
    if (bit_cnt == 4'd8) bit_val = (op_q == OP_READ) ? ack_out_q : 1'b1;  // ack slot
    else bit_val = (op_q == OP_READ) ? 1'b1 : tx_sr[7];
  end

  always_comb begin
    scl_lvl = scl_hold;
    sda_lvl = sda_hold;
    if (busy) begin
      case (op_q)
        OP_START: begin
          scl_lvl = (quarter == 2'd1) || (quarter == 2'd2);
          sda_lvl = (quarter < 2'd2);  // sda falls while scl is high
        end
        OP_STOP: begin
          scl_lvl = (quarter != 2'd0);
          sda_lvl = (quarter >= 2'd2);  // sda rises while scl is high
        end
        default: begin
          scl_lvl = (quarter == 2'd1) || (quarter == 2'd2);
          sda_lvl = bit_val;
        end
      endcase
    end
  end

  assign scl_t_o = scl_lvl;
  assign sda_t_o = sda_lvl;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy     <= 1'b0;
      done_o   <= 1'b0;
      op_q     <= OP_START;
      div_cnt  <= '0;
      quarter  <= '0;
      bit_cnt  <= '0;
      scl_hold <= 1'b1;
      sda_hold <= 1'b1;
    end else begin
      done_o <= 1'b0;
      if (!busy) begin
        if (start_i) begin
          busy    <= 1'b1;
          op_q    <= op_i;
          div_cnt <= '0;
          quarter <= '0;
          bit_cnt <= '0;
        end
      end else if (quarter_end) begin
        div_cnt <= '0;
        quarter <= quarter + 2'd1;
        if (quarter == 2'd3) begin
          if (last_bit) begin
            busy     <= 1'b0;
            done_o   <= 1'b1;
            scl_hold <= scl_lvl;
            sda_hold <= sda_lvl;
          end else begin
            bit_cnt <= bit_cnt + 4'd1;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // sda is sampled at the end of quarter 1, the middle of scl high
  always_ff @(posedge clk) begin
    if (!busy && start_i) begin
      tx_sr     <= wdata_i;
      ack_out_q <= ack_out_i;
    end else if (quarter_end) begin
      if (quarter == 2'd1 && scl_i) begin
        if (bit_cnt == 4'd8) ack_in_o <= sda_i;
        else rdata_o <= {rdata_o[6:0], sda_i};
      end
      if (quarter == 2'd3) tx_sr <= {tx_sr[6:0], 1'b1};
    end
  end

endmodule

//--- i2c_cmd_engine.sv
module i2c_cmd_engine
  import i2c_pkg::*;
(
  input  logic      clk,
  input  logic      rst_i,
  input  i2c_cmd_t  cmd_i,
  input  logic      rqst_i,
  output logic      ready_o,
  output logic      ack_o,
  output cmd_resp_t resp_o,
  output bit_op_e   bm_op_o,
  output logic      bm_start_o,
  output byte_t     bm_wdata_o,
  output logic      bm_ack_out_o,
  input  logic      bm_done_i,
  input  byte_t     bm_rdata_i,
  input  logic      bm_ack_in_i,
  input  logic      scl_t_i,
  input  logic      sda_t_i,
  output logic      scl_i_o,
  output logic      sda_i_o,
  input  logic      scl1_i,
  input  logic      sda1_i,
  output logic      scl1_t_o,
  output logic      sda1_t_o,
  input  logic      scl2_i,
  input  logic      sda2_i,
  output logic      scl2_t_o,
  output logic      sda2_t_o
);

  eng_state_e state;
  eng_state_e next_step;
  i2c_cmd_t   cmd_q;
  bus_sel_t   bus_sel_q;
  logic       issued;   // bit master op of this step already started
  logic       nack_acc;
  byte_t      rd_byte;

  assign ready_o      = (state == ENG_IDLE);
  assign ack_o        = (state == ENG_ACK);
  assign bm_start_o   = (state != ENG_IDLE) && (state != ENG_ACK) && !issued;
  assign bm_ack_out_o = 1'b1;  // single byte reads always end with a nack

  always_comb begin
    bm_op_o    = OP_START;
    bm_wdata_o = '0;
    next_step  = ENG_IDLE;
    case (state)
      ENG_START:   next_step = ENG_DEV_W;
      ENG_DEV_W: begin
        bm_op_o    = OP_WRITE;
        bm_wdata_o = {cmd_q.dev_addr, 1'b0};
        next_step  = ENG_REG;
      end
      ENG_REG: begin
        bm_op_o    = OP_WRITE;
        bm_wdata_o = cmd_q.reg_addr;
        next_step  = cmd_q.rd ? ENG_RESTART : ENG_DATA;
      end
      ENG_DATA: begin
        bm_op_o    = OP_WRITE;
        bm_wdata_o = cmd_q.wdata;
        next_step  = ENG_STOP;
      end
      ENG_RESTART: next_step = ENG_DEV_R;
      ENG_DEV_R: begin
        bm_op_o    = OP_WRITE;
        bm_wdata_o = {cmd_q.dev_addr, 1'b1};
        next_step  = ENG_READ;
      end
      ENG_READ: begin
        bm_op_o   = OP_READ;
        next_step = ENG_STOP;
      end
      ENG_STOP: begin
        bm_op_o   = OP_STOP;
        next_step = ENG_ACK;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state     <= ENG_IDLE;
      issued    <= 1'b0;
      bus_sel_q <= 1'b0;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (rqst_i) begin
            state     <= ENG_START;
            bus_sel_q <= cmd_i.bus_sel;  // held until the next request
          end
        end
        ENG_ACK: state <= ENG_IDLE;
        default: begin
          if (bm_start_o) issued <= 1'b1;
          if (bm_done_i) begin
            issued <= 1'b0;
            state  <= next_step;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ENG_IDLE && rqst_i) begin
      cmd_q    <= cmd_i;
      nack_acc <= 1'b0;
      rd_byte  <= '0;
    end else if (bm_done_i) begin
      if (bm_op_o == OP_WRITE) nack_acc <= nack_acc | bm_ack_in_i;
      if (bm_op_o == OP_READ) rd_byte <= bm_rdata_i;
      if (state == ENG_STOP) begin
        resp_o.nack  <= nack_acc;
        resp_o.rdata <= rd_byte;
      end
    end
  end

  assign scl_i_o = bus_sel_q ? scl2_i : scl1_i;
  assign sda_i_o = bus_sel_q ? sda2_i : sda1_i;

  // the bus that is not selected is always left released
  assign scl1_t_o = bus_sel_q ? 1'b1 : scl_t_i;
  assign sda1_t_o = bus_sel_q ? 1'b1 : sda_t_i;
  assign scl2_t_o = bus_sel_q ? scl_t_i : 1'b1;
  assign sda2_t_o = bus_sel_q ? sda_t_i : 1'b1;

endmodule

//--- i2c_init_seq.sv
module i2c_init_seq
  import i2c_pkg::*;
(
  input  logic        clk,
  input  logic        rst_i,
  input  logic        init_start_i,
  input  i2c_cmd_t    cmd_i,
  input  logic        cmd_rqst_i,
  output logic        cmd_ack_o,
  output cmd_resp_t   cmd_resp_o,
  output logic        init_done_o,
  output logic [31:0] static_ip_o,
  output logic [15:0] alt_mac_o,
  output byte_t       eeprom_config_o,
  output i2c_cmd_t    eng_cmd_o,
  output logic        eng_rqst_o,
  input  logic        eng_ready_i,
  input  logic        eng_ack_i,
  input  cmd_resp_t   eng_resp_i
);

  seq_state_e state;
  step_t      step;
  logic       last_step;

  assign last_step = (state == SEQ_WRITE) ? (step == step_t'(INIT_NUM_WR - 1))
                                          : (step == step_t'(EE_NUM_RD - 1));

  always_comb begin
    eng_cmd_o  = cmd_i;
    eng_rqst_o = 1'b0;
    case (state)
      SEQ_WRITE: begin
        eng_cmd_o.bus_sel  = 1'b0;
        eng_cmd_o.rd       = 1'b0;
        eng_cmd_o.dev_addr = SYNTH_DEV;
        eng_cmd_o.reg_addr = INIT_WR_TABLE[step][0];
        eng_cmd_o.wdata    = INIT_WR_TABLE[step][1];
        eng_rqst_o         = init_start_i & eng_ready_i;
      end
      SEQ_READ: begin
        eng_cmd_o.bus_sel  = 1'b1;
        eng_cmd_o.rd       = 1'b1;
        eng_cmd_o.dev_addr = EEPROM_DEV;
        eng_cmd_o.reg_addr = EE_RD_TABLE[step];
        eng_cmd_o.wdata    = '0;
        eng_rqst_o         = init_start_i & eng_ready_i;
      end
      SEQ_DONE: eng_rqst_o = cmd_rqst_i & eng_ready_i & init_start_i;
      default: ;
    endcase
  end

  assign init_done_o = (state == SEQ_DONE);
  assign cmd_ack_o   = (state == SEQ_DONE) & eng_ack_i;  // only external traffic is acked
  assign cmd_resp_o  = eng_resp_i;

  // ready is low from the cycle after a request through its ack, so
  // leaving on ready never drops a transaction in flight
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state <= SEQ_IDLE;
      step  <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (init_start_i) begin
            state <= SEQ_WRITE;
            step  <= '0;
          end
        end
        SEQ_WRITE: begin
          if (eng_ack_i) begin
            step <= last_step ? '0 : step + 1'b1;
            if (last_step) state <= SEQ_SWITCH;
          end else if (!init_start_i && eng_ready_i) begin
            state <= SEQ_IDLE;
          end
        end
        SEQ_SWITCH: begin
          if (eng_ready_i) state <= init_start_i ? SEQ_READ : SEQ_IDLE;  // bus changes over here
        end
        SEQ_READ: begin
          if (eng_ack_i) begin
            step <= last_step ? '0 : step + 1'b1;
            if (last_step) state <= SEQ_DONE;
          end else if (!init_start_i && eng_ready_i) begin
            state <= SEQ_IDLE;
          end
        end
        SEQ_DONE: begin
          if (!init_start_i && eng_ready_i) state <= SEQ_IDLE;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      static_ip_o     <= '0;
      alt_mac_o       <= '0;
      eeprom_config_o <= '0;
    end else if (state == SEQ_READ && eng_ack_i) begin
      case (step)
        3'd0: static_ip_o[31:24] <= eng_resp_i.rdata;
        3'd1: static_ip_o[23:16] <= eng_resp_i.rdata;
        3'd2: static_ip_o[15:8]  <= eng_resp_i.rdata;
        3'd3: static_ip_o[7:0]   <= eng_resp_i.rdata;
        3'd4: alt_mac_o[15:8]    <= eng_resp_i.rdata;
        3'd5: alt_mac_o[7:0]     <= eng_resp_i.rdata;
        default: eeprom_config_o <= eng_resp_i.rdata;
      endcase
    end
  end

endmodule

//--- i2c_pkg.sv
package i2c_pkg;

  localparam int unsigned I2C_DIV = 4;  // clk cycles per quarter scl period
  localparam int unsigned DIV_W = $clog2(I2C_DIV);

  typedef logic [6:0] dev_addr_t;
  typedef logic [7:0] byte_t;
  typedef logic bus_sel_t;  // 0 selects bus 1, 1 selects bus 2
  typedef logic [2:0] step_t;
  typedef logic [DIV_W-1:0] div_cnt_t;

  localparam dev_addr_t SYNTH_DEV = 7'h6a;
  localparam dev_addr_t EEPROM_DEV = 7'h50;

  localparam int unsigned INIT_NUM_WR = 7;
  localparam int unsigned EE_NUM_RD = 7;

  // register and value pairs for the clock synthesizer
  localparam byte_t INIT_WR_TABLE [INIT_NUM_WR][2] = '{
    '{8'h17, 8'h04},
    '{8'h18, 8'h40},
    '{8'h1e, 8'he8},
    '{8'h1f, 8'h80},
    '{8'h2d, 8'h01},
    '{8'h2e, 8'h10},
    '{8'h60, 8'h3b}
  };

  // ip bytes 3..0, mac bytes 1..0, then the config byte
  localparam byte_t EE_RD_TABLE [EE_NUM_RD] = '{
    8'h8c, 8'h9c, 8'hac, 8'hbc, 8'hcc, 8'hdc, 8'h6c
  };

  typedef struct packed {
    bus_sel_t  bus_sel;
    logic      rd;
    dev_addr_t dev_addr;
    byte_t     reg_addr;
    byte_t     wdata;
  } i2c_cmd_t;

  typedef struct packed {
    logic  nack;
    byte_t rdata;
  } cmd_resp_t;

  typedef enum logic [1:0] {OP_START, OP_STOP, OP_WRITE, OP_READ} bit_op_e;

  typedef enum logic [2:0] {SEQ_IDLE, SEQ_WRITE, SEQ_SWITCH, SEQ_READ, SEQ_DONE} seq_state_e;

  typedef enum logic [3:0] {
    ENG_IDLE, ENG_START, ENG_DEV_W, ENG_REG, ENG_DATA,
    ENG_RESTART, ENG_DEV_R, ENG_READ, ENG_STOP, ENG_ACK
  } eng_state_e;

endpackage

//--- i2c_subsys.sv
module i2c_subsys
  import i2c_pkg::*;
(
  input  logic        clk,
  input  logic        rst_i,
  input  logic        init_start_i,
  input  i2c_cmd_t    cmd_i,
  input  logic        cmd_rqst_i,
  output logic        cmd_ack_o,
  output cmd_resp_t   cmd_resp_o,
  output logic        init_done_o,
  output logic [31:0] static_ip_o,
  output logic [15:0] alt_mac_o,
  output byte_t       eeprom_config_o,
  input  logic        scl1_i,
  input  logic        sda1_i,
  output logic        scl1_t_o,
  output logic        sda1_t_o,
  input  logic        scl2_i,
  input  logic        sda2_i,
  output logic        scl2_t_o,
  output logic        sda2_t_o
);

  i2c_cmd_t  eng_cmd;
  logic      eng_rqst;
  logic      eng_ready;
  logic      eng_ack;
  cmd_resp_t eng_resp;
  bit_op_e   bm_op;
  logic      bm_start;
  byte_t     bm_wdata;
  logic      bm_ack_out;
  logic      bm_done;
  byte_t     bm_rdata;
  logic      bm_ack_in;
  logic      scl_t;
  logic      sda_t;
  logic      scl;
  logic      sda;

  i2c_init_seq i2c_init_seq_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .init_start_i    (init_start_i),
    .cmd_i           (cmd_i),
    .cmd_rqst_i      (cmd_rqst_i),
    .cmd_ack_o       (cmd_ack_o),
    .cmd_resp_o      (cmd_resp_o),
    .init_done_o     (init_done_o),
    .static_ip_o     (static_ip_o),
    .alt_mac_o       (alt_mac_o),
    .eeprom_config_o (eeprom_config_o),
    .eng_cmd_o       (eng_cmd),
    .eng_rqst_o      (eng_rqst),
    .eng_ready_i     (eng_ready),
    .eng_ack_i       (eng_ack),
    .eng_resp_i      (eng_resp)
  );

  i2c_cmd_engine i2c_cmd_engine_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .cmd_i        (eng_cmd),
    .rqst_i       (eng_rqst),
    .ready_o      (eng_ready),
    .ack_o        (eng_ack),
    .resp_o       (eng_resp),
    .bm_op_o      (bm_op),
    .bm_start_o   (bm_start),
    .bm_wdata_o   (bm_wdata),
    .bm_ack_out_o (bm_ack_out),
    .bm_done_i    (bm_done),
    .bm_rdata_i   (bm_rdata),
    .bm_ack_in_i  (bm_ack_in),
    .scl_t_i      (scl_t),
    .sda_t_i      (sda_t),
    .scl_i_o      (scl),
    .sda_i_o      (sda),
    .scl1_i       (scl1_i),
    .sda1_i       (sda1_i),
    .scl1_t_o     (scl1_t_o),
    .sda1_t_o     (sda1_t_o),
    .scl2_i       (scl2_i),
    .sda2_i       (sda2_i),
    .scl2_t_o     (scl2_t_o),
    .sda2_t_o     (sda2_t_o)
  );

  i2c_bit_master i2c_bit_master_inst (
    .clk       (clk),
    .rst_i     (rst_i),
    .op_i      (bm_op),
    .start_i   (bm_start),
    .wdata_i   (bm_wdata),
    .ack_out_i (bm_ack_out),
    .done_o    (bm_done),
    .rdata_o   (bm_rdata),
    .ack_in_o  (bm_ack_in),
    .scl_i     (scl),
    .sda_i     (sda),
    .scl_t_o   (scl_t),
    .sda_t_o   (sda_t)
  );

endmodule

//--- project.f
i2c_pkg.sv
i2c_bit_master.sv
i2c_cmd_engine.sv
i2c_init_seq.sv
i2c_subsys.sv
tb_i2c_slave.sv
tb_i2c_subsys.sv

//--- tb_i2c_slave.sv
module tb_i2c_slave
  import i2c_pkg::*;
(
  input  logic      clk,
  input  logic      rst_i,
  input  dev_addr_t dev_addr_i,
  input  logic      scl_i,
  input  logic      sda_i,
  output logic      sda_t_o,
  output byte_t     wr_cnt_o
);

  typedef enum logic [2:0] {SL_IDLE, SL_ADDR, SL_REG, SL_WDATA, SL_RDATA} slave_state_e;

  byte_t        mem [256];
  slave_state_e state;
  slave_state_e after_ack;
  logic         scl_q;
  logic         sda_q;
  logic [3:0]   bit_cnt;
  logic         in_ack;
  byte_t        rx_sr;
  byte_t        tx_sr;
  byte_t        ptr;
  logic         scl_rise;
  logic         scl_fall;
  logic         start_seen;
  logic         stop_seen;

  // the bus is sampled on clk, so edges are seen one cycle late
  assign scl_rise   = !scl_q && scl_i;
  assign scl_fall   = scl_q && !scl_i;
  assign start_seen = scl_q && scl_i && sda_q && !sda_i;
  assign stop_seen  = scl_q && scl_i && !sda_q && sda_i;

  always @(posedge clk) begin
    if (rst_i) begin
      state    <= SL_IDLE;
      scl_q    <= 1'b1;
      sda_q    <= 1'b1;
      sda_t_o  <= 1'b1;
      bit_cnt  <= '0;
      in_ack   <= 1'b0;
      ptr      <= '0;
      wr_cnt_o <= '0;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
      if (start_seen) begin
        state   <= SL_ADDR;  // a repeated start lands here too
        bit_cnt <= '0;
        in_ack  <= 1'b0;
        sda_t_o <= 1'b1;
      end else if (stop_seen) begin
        state   <= SL_IDLE;
        sda_t_o <= 1'b1;
      end else if (state != SL_IDLE && scl_rise) begin
        if (bit_cnt < 4'd8) begin
          bit_cnt <= bit_cnt + 4'd1;
          rx_sr   <= {rx_sr[6:0], sda_i};
        end else if (state == SL_RDATA) begin
          state <= SL_IDLE;  // master ack slot ends the single byte
        end
      end else if (state != SL_IDLE && scl_fall) begin
        if (state == SL_RDATA) begin
          if (bit_cnt < 4'd8) begin
            sda_t_o <= tx_sr[6];
            tx_sr   <= {tx_sr[6:0], 1'b1};
          end else begin
            sda_t_o <= 1'b1;
          end
        end else if (in_ack) begin
          in_ack  <= 1'b0;
          bit_cnt <= '0;
          state   <= after_ack;
          sda_t_o <= 1'b1;
          if (after_ack == SL_RDATA) begin
            sda_t_o <= mem[ptr][7];
            tx_sr   <= mem[ptr];
          end
        end else if (bit_cnt == 4'd8) begin
          case (state)
            SL_ADDR: begin
              if (rx_sr[7:1] == dev_addr_i) begin
                in_ack    <= 1'b1;
                sda_t_o   <= 1'b0;
                after_ack <= rx_sr[0] ? SL_RDATA : SL_REG;
              end else begin
                state <= SL_IDLE;  // not our address, stay off the bus
              end
            end
            SL_REG: begin
              ptr       <= rx_sr;
              in_ack    <= 1'b1;
              sda_t_o   <= 1'b0;
              after_ack <= SL_WDATA;
            end
            SL_WDATA: begin
              mem[ptr]  <= rx_sr;
              ptr       <= ptr + 8'd1;
              wr_cnt_o  <= wr_cnt_o + 8'd1;
              in_ack    <= 1'b1;
              sda_t_o   <= 1'b0;
              after_ack <= SL_WDATA;
            end
            default: ;
          endcase
        end
      end
    end
  end

endmodule

//--- tb_i2c_subsys.sv
module tb_i2c_subsys
  import i2c_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 40 * 40 * 4 * I2C_DIV;

  typedef struct packed {
    logic [31:0] ip;
    logic [15:0] mac;
    byte_t       cfg;
  } ee_image_t;

  logic        clk = 1'b0;
  logic        rst_i;
  logic        init_start_i;
  i2c_cmd_t    cmd_i;
  logic        cmd_rqst_i;
  logic        cmd_ack_o;
  cmd_resp_t   cmd_resp_o;
  logic        init_done_o;
  logic [31:0] static_ip_o;
  logic [15:0] alt_mac_o;
  byte_t       eeprom_config_o;
  logic        scl1_t;
  logic        sda1_t;
  logic        scl2_t;
  logic        sda2_t;
  logic        synth_sda_t;
  logic        eeprom_sda_t;
  logic        scl1;
  logic        sda1;
  logic        scl2;
  logic        sda2;
  byte_t       synth_wr_cnt;
  byte_t       eeprom_wr_cnt;
  byte_t       ee_contents [256];
  ee_image_t   exp_img;
  logic        done_seen = 1'b0;
  int          init_checks = 0;
  int          ack_count = 0;
  int          cycle_cnt = 0;

  always #4 clk = ~clk;

  // pull-ups keep a line high unless some enable pulls it low
  assign scl1 = scl1_t;
  assign sda1 = sda1_t & synth_sda_t;
  assign scl2 = scl2_t;
  assign sda2 = sda2_t & eeprom_sda_t;

  i2c_subsys i2c_subsys_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .init_start_i    (init_start_i),
    .cmd_i           (cmd_i),
    .cmd_rqst_i      (cmd_rqst_i),
    .cmd_ack_o       (cmd_ack_o),
    .cmd_resp_o      (cmd_resp_o),
    .init_done_o     (init_done_o),
    .static_ip_o     (static_ip_o),
    .alt_mac_o       (alt_mac_o),
    .eeprom_config_o (eeprom_config_o),
    .scl1_i          (scl1),
    .sda1_i          (sda1),
    .scl1_t_o        (scl1_t),
    .sda1_t_o        (sda1_t),
    .scl2_i          (scl2),
    .sda2_i          (sda2),
    .scl2_t_o        (scl2_t),
    .sda2_t_o        (sda2_t)
  );

  tb_i2c_slave synth_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .dev_addr_i (SYNTH_DEV),
    .scl_i      (scl1),
    .sda_i      (sda1),
    .sda_t_o    (synth_sda_t),
    .wr_cnt_o   (synth_wr_cnt)
  );

  tb_i2c_slave eeprom_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .dev_addr_i (EEPROM_DEV),
    .scl_i      (scl2),
    .sda_i      (sda2),
    .sda_t_o    (eeprom_sda_t),
    .wr_cnt_o   (eeprom_wr_cnt)
  );

  // expected outputs straight from the eeprom offsets table
  function automatic ee_image_t expected_image(input byte_t contents [256]);
    ee_image_t img;
    img.ip  = {contents[EE_RD_TABLE[0]], contents[EE_RD_TABLE[1]],
               contents[EE_RD_TABLE[2]], contents[EE_RD_TABLE[3]]};
    img.mac = {contents[EE_RD_TABLE[4]], contents[EE_RD_TABLE[5]]};
    img.cfg = contents[EE_RD_TABLE[6]];
    return img;
  endfunction

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_resp(input string name, input cmd_resp_t exp, input cmd_resp_t act);
    if (act !== exp) begin
      $display("Error in %s: expected nack %b rdata %h, actual nack %b rdata %h",
               name, exp.nack, exp.rdata, act.nack, act.rdata);
      abort_run();
    end
  endtask

  task automatic check_ip(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error in %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_mac(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("Error in %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("Error in %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error in %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic fill_eeprom();
    for (int i = 0; i < 256; i++) begin
      ee_contents[i]     = byte_t'($urandom);
      eeprom_inst.mem[i] = ee_contents[i];
    end
  endtask

  // one request pulse, then wait for the ack and take the response with it
  task automatic run_command(input i2c_cmd_t cmd, output cmd_resp_t resp);
    int acks_before;
    acks_before = ack_count;
    @(posedge clk);
    cmd_i      <= cmd;
    cmd_rqst_i <= 1'b1;
    @(posedge clk);
    cmd_rqst_i <= 1'b0;
    do @(negedge clk); while (!cmd_ack_o);
    resp = cmd_resp_o;
    repeat (4 * I2C_DIV) @(negedge clk);
    check_byte("ack pulses per command", 8'd1, byte_t'(ack_count - acks_before));
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  always @(negedge clk) begin
    if (cmd_ack_o) ack_count++;
    if (!rst_i && !(scl1_t && sda1_t) && !(scl2_t && sda2_t)) begin
      $display("Both buses had a low enable in the same cycle, bus isolation is broken");
      abort_run();
    end
  end

  // compares the stored eeprom values each time init completes
  always @(negedge clk) begin
    if (init_done_o && !done_seen) begin
      exp_img = expected_image(ee_contents);
      check_ip("static ip after init", exp_img.ip, static_ip_o);
      check_mac("alt mac after init", exp_img.mac, alt_mac_o);
      check_byte("eeprom config after init", exp_img.cfg, eeprom_config_o);
      init_checks++;
    end
    done_seen = init_done_o;
  end

  initial begin : main_flow
    i2c_cmd_t  cmd;
    cmd_resp_t resp;
    cmd_resp_t exp_resp;
    byte_t     offset;
    byte_t     wdata;
    ee_image_t first_image;

    void'($urandom(57));
    rst_i        = 1'b1;
    init_start_i = 1'b0;
    cmd_i        = '0;
    cmd_rqst_i   = 1'b0;
    for (int i = 0; i < 256; i++) begin
      synth_inst.mem[i] = byte_t'(i) ^ 8'ha5;
    end
    fill_eeprom();

    repeat (8) @(posedge clk);
    rst_i <= 1'b0;
    repeat (2) @(negedge clk);
    check_byte("bus enables after reset", 8'h0f, {4'h0, scl1_t, sda1_t, scl2_t, sda2_t});
    check_flag("init done after reset", 1'b0, init_done_o);
    check_ip("static ip after reset", '0, static_ip_o);
    check_mac("alt mac after reset", '0, alt_mac_o);
    check_byte("eeprom config after reset", '0, eeprom_config_o);

    @(posedge clk);
    init_start_i <= 1'b1;
    while (init_checks < 1) @(negedge clk);
    for (int i = 0; i < INIT_NUM_WR; i++) begin
      check_byte($sformatf("synth register %h", INIT_WR_TABLE[i][0]),
                 INIT_WR_TABLE[i][1], synth_inst.mem[INIT_WR_TABLE[i][0]]);
    end
    check_byte("synth writes during init", byte_t'(INIT_NUM_WR), synth_wr_cnt);
    check_byte("eeprom writes during init", 8'd0, eeprom_wr_cnt);
    check_byte("command acks during init", 8'd0, byte_t'(ack_count));
    first_image = expected_image(ee_contents);

    offset = byte_t'($urandom);
    wdata  = ~ee_contents[offset];  // always differs from what the eeprom holds
    cmd.bus_sel  = 1'b1;
    cmd.rd       = 1'b0;
    cmd.dev_addr = EEPROM_DEV;
    cmd.reg_addr = offset;
    cmd.wdata    = wdata;
    run_command(cmd, resp);
    check_flag("nack of external eeprom write", 1'b0, resp.nack);
    ee_contents[offset] = wdata;
    cmd.rd = 1'b1;
    run_command(cmd, resp);
    exp_resp.nack  = 1'b0;
    exp_resp.rdata = wdata;
    check_resp("external eeprom read back", exp_resp, resp);
    cmd.dev_addr = 7'h33;  // nothing answers here
    run_command(cmd, resp);
    check_flag("nack from absent device", 1'b1, resp.nack);

    @(posedge clk);
    init_start_i <= 1'b0;
    do @(negedge clk); while (init_done_o);
    check_ip("static ip kept after init stop", first_image.ip, static_ip_o);
    check_mac("alt mac kept after init stop", first_image.mac, alt_mac_o);
    check_byte("eeprom config kept after init stop", first_image.cfg, eeprom_config_o);
    fill_eeprom();
    @(posedge clk);
    init_start_i <= 1'b1;
    while (init_checks < 2) @(negedge clk);

    $display("Test OK");
    $finish;
  end

endmodule
